//--- dv/iq_tb.sv
// --------------------
// iq demodulator testbench
// register readback, demod rows from a table,
// low-pass settling and averager sums
// --------------------
module iq_tb;
  import iq_params_pkg::*;
  import iq_types_pkg::*;

  localparam int NUM_ROWS = 24;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + 2000;
  localparam int AVG_POLL_LIMIT = 500;
  localparam logic [31:0] SEED = 32'h1c1f_c18f;
  localparam logic [PHASE_BITS-1:0] NO_SHIFT = '0;
  localparam logic [PHASE_BITS-1:0] QUARTER_SHIFT = PHASE_BITS'(1) << (PHASE_BITS - 2);
  localparam logic signed [SIGNAL_BITS-1:0] MAX_SAMPLE = SIGNAL_BITS'((1 << (SIGNAL_BITS - 1)) - 1);
  localparam logic signed [SIGNAL_BITS-1:0] MIN_SAMPLE = SIGNAL_BITS'(1 << (SIGNAL_BITS - 1));

  // writable registers and their field masks
  localparam logic [ADDR_BITS-1:0] CFG_ADDRS [6] = '{REG_PHASE_INC, REG_PHASE_SHIFT,
    REG_OUT_SEL, REG_LPF_SHIFT, REG_NA_AVG, REG_NA_SLEEP};
  localparam logic [DATA_BITS-1:0] CFG_MASKS [6] = '{32'hffff_ffff, 32'hffff_ffff,
    32'h0000_000f, 32'h0000_001f, 32'hffff_ffff, 32'hffff_ffff};
  localparam logic [ADDR_BITS-1:0] UNMAPPED [4] = '{16'h0000, 16'h0100, 16'h0128, 16'h0200};

  // one table row, stimulus then expectation
  typedef struct packed {
    logic signed [SIGNAL_BITS-1:0] dat;
    logic [PHASE_BITS-1:0]         phase_shift;
    logic [OUT_SEL_BITS-1:0]       out_sel;
    logic [LPF_SHIFT_BITS-1:0]     lpf_shift;
    logic signed [SIGNAL_BITS-1:0] exp_sig;
    logic signed [SIGNAL_BITS-1:0] exp_sig2;
    logic [3:0]                    tol;  // lsb slack while filtering
  } row_t;

  logic                          clk_i;
  logic                          rstn_i;
  logic                          sync_i;
  logic signed [SIGNAL_BITS-1:0] dat_i;
  logic [ADDR_BITS-1:0]          addr_i;
  logic                          wen_i;
  logic                          ren_i;
  logic [DATA_BITS-1:0]          wdata_i;
  logic                          ack_o;
  logic [DATA_BITS-1:0]          rdata_o;
  logic signed [SIGNAL_BITS-1:0] signal_o;
  logic signed [SIGNAL_BITS-1:0] signal2_o;

  row_t rows [NUM_ROWS];

  iq_top #(.SIGNAL_BITS(SIGNAL_BITS), .LUT_SZ(LUT_SZ), .PHASE_BITS(PHASE_BITS)) DUT (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .sync_i    (sync_i),
    .dat_i     (dat_i),
    .addr_i    (addr_i),
    .wen_i     (wen_i),
    .ren_i     (ren_i),
    .wdata_i   (wdata_i),
    .ack_o     (ack_o),
    .rdata_o   (rdata_o),
    .signal_o  (signal_o),
    .signal2_o (signal2_o)
  );

  always #10 clk_i = ~clk_i;  // period 20

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic next_drive_point();
    @(posedge clk_i);
    #2;  // clear of the edge
  endtask

  task automatic check_signal(input string name, input logic signed [SIGNAL_BITS-1:0] got,
                              input logic signed [SIGNAL_BITS-1:0] exp, input int tol);
    int diff;
    diff = int'(got) - int'(exp);
    if (diff > tol || diff < -tol) begin
      fail_run($sformatf("Fail at %0t: %s is %0d, expected %0d (+/- %0d)",
                         $time, name, got, exp, tol));
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] got,
                            input logic [DATA_BITS-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp));
    end
  endtask

  // sum half readback is busy on top of 31 sum bits
  task automatic check_sum_half(input string name, input logic [DATA_BITS-1:0] got,
                                input logic signed [SUM_BITS-1:0] exp_sum, input bit upper);
    logic [DATA_BITS-1:0] exp_word;
    if (upper) exp_word = {1'b0, exp_sum[SUM_BITS-1:DATA_BITS-1]};
    else exp_word = {1'b0, exp_sum[DATA_BITS-2:0]};
    check_word(name, got, exp_word);
  endtask

  task automatic expect_ack(input logic [ADDR_BITS-1:0] addr);
    if (ack_o !== 1'b1) begin
      fail_run($sformatf("no ack one cycle after the bus access to 0x%04h at %0t", addr, $time));
    end
  endtask

  task automatic bus_write(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data);
    addr_i  = addr;
    wdata_i = data;
    wen_i   = 1'b1;
    next_drive_point();
    wen_i = 1'b0;
    expect_ack(addr);
  endtask

  task automatic bus_read(input logic [ADDR_BITS-1:0] addr, output logic [DATA_BITS-1:0] data);
    addr_i = addr;
    ren_i  = 1'b1;
    next_drive_point();
    ren_i = 1'b0;
    expect_ack(addr);
    data = rdata_o;  // registered, stable until the next edge
  endtask

  function automatic logic signed [SIGNAL_BITS-1:0] rand_sample();
    return SIGNAL_BITS'($urandom);
  endfunction

  // floor(x * 65535 / 64)
  function automatic longint scaled_product(input logic signed [SIGNAL_BITS-1:0] x);
    longint p;
    p = longint'(x) * 64'sd65535;
    return p >>> DEMOD_SHIFT;
  endfunction

  // top SIGNAL_BITS of a quadrature, saturated
  function automatic logic signed [SIGNAL_BITS-1:0] top_bits(input longint v);
    longint t;
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (SIGNAL_BITS - 1)) - 1;
    lo = -(longint'(1) <<< (SIGNAL_BITS - 1));
    t = v >>> (LPF_BITS - SIGNAL_BITS);
    if (t > hi) t = hi;
    if (t < lo) t = lo;
    return t[SIGNAL_BITS-1:0];
  endfunction

  function automatic row_t make_row(input logic signed [SIGNAL_BITS-1:0] x,
                                    input logic [PHASE_BITS-1:0] ps,
                                    input logic [OUT_SEL_BITS-1:0] sel,
                                    input logic [LPF_SHIFT_BITS-1:0] shift);
    row_t r;
    logic signed [SIGNAL_BITS-1:0] prod;
    logic signed [SIGNAL_BITS-1:0] i_exp;
    logic signed [SIGNAL_BITS-1:0] q_exp;
    prod = top_bits(scaled_product(x));
    if (ps == QUARTER_SHIFT) begin
      i_exp = '0;    // cos at zero
      q_exp = prod;  // sin at full scale
    end else begin
      i_exp = prod;
      q_exp = '0;
    end
    r.dat = x;
    r.phase_shift = ps;
    r.out_sel = sel;
    r.lpf_shift = shift;
    case (sel)
      SEL_QUAD:   r.exp_sig = i_exp;
      SEL_DIRECT: r.exp_sig = x;
      default:    r.exp_sig = '0;
    endcase
    r.exp_sig2 = q_exp;
    r.tol = (shift == '0) ? 4'd0 : 4'd1;
    return r;
  endfunction

  function automatic void build_table();
    int idx;
    rows[0] = make_row(rand_sample(), NO_SHIFT, SEL_QUAD, 5'd0);
    rows[1] = make_row(MAX_SAMPLE, NO_SHIFT, SEL_QUAD, 5'd0);
    rows[2] = make_row(MIN_SAMPLE, NO_SHIFT, SEL_QUAD, 5'd0);
    rows[3] = make_row(rand_sample(), QUARTER_SHIFT, SEL_QUAD, 5'd0);
    rows[4] = make_row(MIN_SAMPLE, QUARTER_SHIFT, SEL_QUAD, 5'd0);
    rows[5] = make_row(rand_sample(), NO_SHIFT, SEL_DIRECT, 5'd0);
    idx = 6;
    for (int c = 2; c < 16; c++) begin  // every unused select code
      rows[idx] = make_row(rand_sample(), (c % 2 == 1) ? QUARTER_SHIFT : NO_SHIFT,
                           OUT_SEL_BITS'(c), 5'd0);
      idx++;
    end
    rows[20] = make_row(rand_sample(), NO_SHIFT, SEL_QUAD, 5'd1);
    rows[21] = make_row(rand_sample(), NO_SHIFT, SEL_QUAD, 5'd2);
    rows[22] = make_row(rand_sample(), NO_SHIFT, SEL_QUAD, 5'd3);
    rows[23] = make_row(rand_sample(), QUARTER_SHIFT, SEL_QUAD, 5'd2);
  endfunction

  // slower filters get a longer wait
  function automatic int settle_cycles(input logic [LPF_SHIFT_BITS-1:0] shift);
    if (shift == '0) return 16;
    return 16 + (32 << shift);
  endfunction

  task automatic test_registers();
    logic [DATA_BITS-1:0] wval;
    logic [DATA_BITS-1:0] rval;
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < 6; k++) begin
        wval = $urandom & CFG_MASKS[k];
        bus_write(CFG_ADDRS[k], wval);
        bus_read(CFG_ADDRS[k], rval);
        check_word($sformatf("rdata_o at 0x%04h", CFG_ADDRS[k]), rval, wval);
      end
    end
    for (int k = 0; k < 4; k++) begin
      bus_read(UNMAPPED[k], rval);
      check_word($sformatf("rdata_o at 0x%04h", UNMAPPED[k]), rval, '0);
    end
  endtask

  // freeze the nco at phase zero
  task automatic restore_nco();
    bus_write(REG_PHASE_INC, '0);
    sync_i = 1'b1;
    repeat (2) next_drive_point();
    sync_i = 1'b0;
  endtask

  task automatic apply_row(input int n);
    row_t r;
    r = rows[n];
    bus_write(REG_PHASE_SHIFT, r.phase_shift);
    bus_write(REG_OUT_SEL, DATA_BITS'(r.out_sel));
    bus_write(REG_LPF_SHIFT, DATA_BITS'(r.lpf_shift));
    dat_i = r.dat;
    repeat (settle_cycles(r.lpf_shift)) next_drive_point();
    check_signal($sformatf("signal_o row %0d", n), signal_o, r.exp_sig, int'(r.tol));
    check_signal($sformatf("signal2_o row %0d", n), signal2_o, r.exp_sig2, int'(r.tol));
  endtask

  task automatic run_average(input logic [PHASE_BITS-1:0] ps, input int m);
    logic signed [SIGNAL_BITS-1:0] x;
    longint p;
    sum_pair_t exp_sums;
    logic [DATA_BITS-1:0] rval;
    int polls;
    x = rand_sample();
    p = scaled_product(x);  // constant quadrature value
    if (ps == QUARTER_SHIFT) begin
      exp_sums.i = '0;
      exp_sums.q = SUM_BITS'(p * m);
    end else begin
      exp_sums.i = SUM_BITS'(p * m);
      exp_sums.q = '0;
    end
    bus_write(REG_PHASE_SHIFT, ps);
    bus_write(REG_OUT_SEL, '0);
    bus_write(REG_LPF_SHIFT, '0);  // bypass
    bus_write(REG_NA_SLEEP, 32'd10);
    bus_write(REG_NA_AVG, DATA_BITS'(m));
    dat_i = x;
    repeat (16) next_drive_point();  // pipeline full
    bus_write(REG_PHASE_INC, '0);    // start pulse
    next_drive_point();
    bus_read(REG_SUM_I_LO, rval);
    if (rval[DATA_BITS-1] !== 1'b1) fail_run("averager busy flag did not rise after the start");
    polls = 0;
    while (rval[DATA_BITS-1] === 1'b1) begin
      if (polls == AVG_POLL_LIMIT) fail_run("averager still busy after the poll limit");
      polls++;
      bus_read(REG_SUM_I_LO, rval);
    end
    check_sum_half("sum i low half", rval, exp_sums.i, 1'b0);
    bus_read(REG_SUM_I_HI, rval);
    check_sum_half("sum i high half", rval, exp_sums.i, 1'b1);
    bus_read(REG_SUM_Q_LO, rval);
    check_sum_half("sum q low half", rval, exp_sums.q, 1'b0);
    bus_read(REG_SUM_Q_HI, rval);
    check_sum_half("sum q high half", rval, exp_sums.q, 1'b1);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    void'($urandom(SEED));
    clk_i   = 1'b0;
    rstn_i  = 1'b0;
    sync_i  = 1'b0;
    dat_i   = '0;
    addr_i  = '0;
    wen_i   = 1'b0;
    ren_i   = 1'b0;
    wdata_i = '0;
    build_table();
    repeat (8) @(posedge clk_i);
    #2;
    rstn_i = 1'b1;
    if (ack_o !== 1'b0) fail_run("ack_o is not low after reset");
    test_registers();
    restore_nco();
    for (int n = 0; n < NUM_ROWS; n++) begin
      apply_row(n);
    end
    run_average(NO_SHIFT, 16 + int'($urandom % 48));
    run_average(QUARTER_SHIFT, 16 + int'($urandom % 48));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- include/sin_lut.svh
// --------------------
// sine table
// one full period, 64 points, peak 65535
// --------------------
`ifndef SIN_LUT_SVH
`define SIN_LUT_SVH

// entry k is round(65535 * sin(2*pi*k/64))
localparam logic signed [iq_params_pkg::LUT_BITS-1:0]
  SIN_LUT [iq_params_pkg::LUT_DEPTH] = '{
    0,      6424,   12785,  19024,  25079,  30893,  36409,  41575,   // rising
    46340,  50659,  54490,  57797,  60546,  62713,  64276,  65219,
    65535,  65219,  64276,  62713,  60546,  57797,  54490,  50659,   // peak
    46340,  41575,  36409,  30893,  25079,  19024,  12785,  6424,
    0,      -6424,  -12785, -19024, -25079, -30893, -36409, -41575,  // negative half
    -46340, -50659, -54490, -57797, -60546, -62713, -64276, -65219,
    -65535, -65219, -64276, -62713, -60546, -57797, -54490, -50659,  // trough
    -46340, -41575, -36409, -30893, -25079, -19024, -12785, -6424
  };

`endif

//--- list.f
+incdir+include
logic/iq_params_pkg.sv
logic/iq_types_pkg.sv
logic/iq_regs.sv
logic/iq_nco.sv
logic/iq_demod.sv
logic/iq_lowpass.sv
logic/iq_averager.sv
logic/iq_output_stage.sv
logic/iq_top.sv
dv/iq_tb.sv

//--- logic/iq_averager.sv
// --------------------
// network analyzer averager
// waits out settling, then sums
// both quadratures over a window
// --------------------
module iq_averager (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      start_i,
  input  iq_types_pkg::iq_cfg_t     cfg_i,
  input  iq_types_pkg::quad_pair_t  quad_i,
  output iq_types_pkg::sum_pair_t   sums_o,
  output logic                      busy_o
);
  import iq_params_pkg::*;

  logic [CNT_BITS-1:0] avg_left;    // samples still to sum
  logic [CNT_BITS-1:0] sleep_left;  // settling cycles still to wait

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      sums_o     <= '0;
      avg_left   <= '0;
      sleep_left <= '0;
      busy_o     <= 1'b0;
    end else if (start_i) begin
      // new sweep point
      sums_o     <= '0;
      avg_left   <= cfg_i.na_avg;
      sleep_left <= cfg_i.na_sleep;
      busy_o     <= 1'b1;
    end else if (avg_left == '0) begin
      busy_o <= 1'b0;  // done, sums frozen
    end else if (sleep_left == '0) begin
      avg_left <= avg_left - 1'b1;
      sums_o.i <= sums_o.i + SUM_BITS'(quad_i.i);  // sign extended
      sums_o.q <= sums_o.q + SUM_BITS'(quad_i.q);
    end else begin
      sleep_left <= sleep_left - 1'b1;  // still settling
    end
  end

  // results hold steady for readback between sweeps
  a_sums_hold_idle: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (!busy_o && !start_i) |=> $stable(sums_o)
  );

endmodule

//--- logic/iq_demod.sv
// --------------------
// iq demodulator
// sample times reference pair, scaled
// two pipeline stages
// --------------------
module iq_demod #(
  parameter int SIGNAL_BITS = iq_params_pkg::SIGNAL_BITS
) (
  input  logic                           clk_i,
  input  logic signed [SIGNAL_BITS-1:0]  dat_i,
  input  iq_types_pkg::ref_pair_t        ref_i,
  output iq_types_pkg::quad_pair_t       quad_o
);
  import iq_params_pkg::*;

  localparam int PROD_BITS = SIGNAL_BITS + LUT_BITS;  // full product

  logic signed [PROD_BITS-1:0] prod_i_q;  // stage 1
  logic signed [PROD_BITS-1:0] prod_q_q;

  always_ff @(posedge clk_i) begin
    // stage 1: multiply
    prod_i_q <= dat_i * ref_i.cos;  // in phase
    prod_q_q <= dat_i * ref_i.sin;  // quadrature
    // stage 2: scale down, result fits LPF_BITS for a full scale table
    quad_o.i <= LPF_BITS'(prod_i_q >>> DEMOD_SHIFT);
    quad_o.q <= LPF_BITS'(prod_q_q >>> DEMOD_SHIFT);
  end

endmodule

//--- logic/iq_lowpass.sv
// --------------------
// iq low-pass
// first order shift filter on both quadratures
// shift of zero bypasses
// --------------------
module iq_lowpass (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  iq_types_pkg::iq_cfg_t     cfg_i,
  input  iq_types_pkg::quad_pair_t  quad_i,
  output iq_types_pkg::quad_pair_t  quad_o
);
  import iq_params_pkg::*;

  // one filter step: y += (x - y) >>> k
  function automatic logic signed [LPF_BITS-1:0] lp_step(
    input logic signed [LPF_BITS-1:0]  state,
    input logic signed [LPF_BITS-1:0]  target,
    input logic [LPF_SHIFT_BITS-1:0]   shift
  );
    logic signed [LPF_BITS:0] diff;  // one guard bit
    logic signed [LPF_BITS:0] next;
    if (shift == '0) begin
      return target;  // bypass
    end
    diff = target - state;
    next = state + (diff >>> shift);  // stays between state and target
    return next[LPF_BITS-1:0];
  endfunction

  // state doubles as the output register
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      quad_o <= '0;
    end else begin
      quad_o.i <= lp_step(quad_o.i, quad_i.i, cfg_i.lpf_shift);
      quad_o.q <= lp_step(quad_o.q, quad_i.q, cfg_i.lpf_shift);
    end
  end

endmodule

//--- logic/iq_nco.sv
// --------------------
// iq nco
// phase accumulator and table lookup
// for the sin/cos reference pair
// --------------------
module iq_nco #(
  parameter int LUT_SZ     = iq_params_pkg::LUT_SZ,
  parameter int PHASE_BITS = iq_params_pkg::PHASE_BITS
) (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    sync_i,
  input  iq_types_pkg::iq_cfg_t   cfg_i,
  output iq_types_pkg::ref_pair_t ref_o
);
  `include "sin_lut.svh"

  localparam int QUARTER = 1 << (LUT_SZ - 2);  // cos leads sin by 90 deg

  logic [PHASE_BITS-1:0] phase_q;
  logic [PHASE_BITS-1:0] phase_shifted;
  logic [LUT_SZ-1:0]     sin_idx;
  logic [LUT_SZ-1:0]     cos_idx;

  // accumulator
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      phase_q <= '0;
    end else if (sync_i) begin
      phase_q <= '0;  // held at zero while sync is high
    end else begin
      phase_q <= phase_q + cfg_i.phase_inc[PHASE_BITS-1:0];  // wraps
    end
  end

  assign phase_shifted = phase_q + cfg_i.phase_shift[PHASE_BITS-1:0];
  assign sin_idx = phase_shifted[PHASE_BITS-1 -: LUT_SZ];  // top bits index the table
  assign cos_idx = sin_idx + LUT_SZ'(QUARTER);              // wraps around the period

  // registered lookup, one cycle behind the phase
  always_ff @(posedge clk_i) begin
    ref_o.sin <= SIN_LUT[sin_idx];
    ref_o.cos <= SIN_LUT[cos_idx];
  end

endmodule

//--- logic/iq_output_stage.sv
// --------------------
// iq output stage
// saturating narrowing and signal_o select
// --------------------
module iq_output_stage #(
  parameter int SIGNAL_BITS = iq_params_pkg::SIGNAL_BITS
) (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  input  logic signed [SIGNAL_BITS-1:0]  dat_i,
  input  iq_types_pkg::iq_cfg_t          cfg_i,
  input  iq_types_pkg::quad_pair_t       quad_i,
  output logic signed [SIGNAL_BITS-1:0]  signal_o,
  output logic signed [SIGNAL_BITS-1:0]  signal2_o
);
  import iq_params_pkg::*;

  localparam int DROP = LPF_BITS - SIGNAL_BITS;  // low bits discarded
  localparam logic signed [LPF_BITS-1:0] SAT_MAX = LPF_BITS'(2 ** (SIGNAL_BITS - 1) - 1);
  localparam logic signed [LPF_BITS-1:0] SAT_MIN = LPF_BITS'(-(2 ** (SIGNAL_BITS - 1)));

  // top bits of a quadrature, clamped to the output range
  function automatic logic signed [SIGNAL_BITS-1:0] narrow(
    input logic signed [LPF_BITS-1:0] v
  );
    logic signed [LPF_BITS-1:0] s;
    s = v >>> DROP;
    if (s > SAT_MAX) return SAT_MAX[SIGNAL_BITS-1:0];
    if (s < SAT_MIN) return SAT_MIN[SIGNAL_BITS-1:0];
    return s[SIGNAL_BITS-1:0];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      signal_o  <= '0;
      signal2_o <= '0;
    end else begin
      case (cfg_i.out_sel)
        SEL_QUAD:   signal_o <= narrow(quad_i.i);
        SEL_DIRECT: signal_o <= dat_i;  // raw sample, registered
        default:    signal_o <= '0;
      endcase
      signal2_o <= narrow(quad_i.q);  // always q
    end
  end

  a_unknown_sel_zero: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (cfg_i.out_sel > SEL_DIRECT) |=> (signal_o == '0)
  );

endmodule

//--- logic/iq_params_pkg.sv
// --------------------
// iq demodulator parameters
// widths, register map and output select codes
// --------------------
package iq_params_pkg;

  // datapath widths
  localparam int SIGNAL_BITS = 14;  // adc sample
  localparam int LUT_SZ      = 6;   // log2 of sine table depth
  localparam int LUT_BITS    = 17;  // table word, peak 65535
  localparam int PHASE_BITS  = 32;  // nco accumulator
  localparam int LPF_BITS    = 24;  // quadrature width
  localparam int DEMOD_SHIFT = 6;   // scaling after multiply
  localparam int SUM_BITS    = 62;  // averager sums

  // bus
  localparam int ADDR_BITS = 16;
  localparam int DATA_BITS = 32;

  // config field widths
  localparam int OUT_SEL_BITS   = 4;
  localparam int LPF_SHIFT_BITS = 5;  // shift of 0 bypasses the filter

  // derived
  localparam int LUT_DEPTH = 1 << LUT_SZ;
  localparam int CNT_BITS  = DATA_BITS;  // averager counters take a full bus word

  // register map
  localparam logic [ADDR_BITS-1:0] REG_PHASE_INC   = 16'h0104;  // write also starts averager
  localparam logic [ADDR_BITS-1:0] REG_PHASE_SHIFT = 16'h0108;
  localparam logic [ADDR_BITS-1:0] REG_OUT_SEL     = 16'h010C;
  localparam logic [ADDR_BITS-1:0] REG_LPF_SHIFT   = 16'h0124;
  localparam logic [ADDR_BITS-1:0] REG_NA_AVG      = 16'h0130;
  localparam logic [ADDR_BITS-1:0] REG_NA_SLEEP    = 16'h0134;
  localparam logic [ADDR_BITS-1:0] REG_SUM_I_LO    = 16'h0140;
  localparam logic [ADDR_BITS-1:0] REG_SUM_I_HI    = 16'h0144;
  localparam logic [ADDR_BITS-1:0] REG_SUM_Q_LO    = 16'h0148;
  localparam logic [ADDR_BITS-1:0] REG_SUM_Q_HI    = 16'h014C;

  // signal_o select, anything else gives zero
  localparam logic [OUT_SEL_BITS-1:0] SEL_QUAD   = 4'd0;
  localparam logic [OUT_SEL_BITS-1:0] SEL_DIRECT = 4'd1;

endpackage

//--- logic/iq_regs.sv
// --------------------
// iq register bank
// bus decode, config registers, readback
// and the averager start pulse
// --------------------
module iq_regs (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,
  input  logic [iq_params_pkg::ADDR_BITS-1:0]  addr_i,
  input  logic                                 wen_i,
  input  logic                                 ren_i,
  input  logic [iq_params_pkg::DATA_BITS-1:0]  wdata_i,
  output logic                                 ack_o,
  output logic [iq_params_pkg::DATA_BITS-1:0]  rdata_o,
  output iq_types_pkg::iq_cfg_t                cfg_o,
  output logic                                 start_o,
  input  iq_types_pkg::sum_pair_t              sums_i,
  input  logic                                 busy_i
);
  import iq_params_pkg::*;

  // config writes and control strobes
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cfg_o   <= '0;  // out_sel 0 is SEL_QUAD
      ack_o   <= 1'b0;
      start_o <= 1'b0;
    end else begin
      ack_o   <= wen_i | ren_i;                       // ack follows any access
      start_o <= wen_i && (addr_i == REG_PHASE_INC);  // new frequency, new sweep point
      if (wen_i) begin
        case (addr_i)
          REG_PHASE_INC:   cfg_o.phase_inc   <= wdata_i;
          REG_PHASE_SHIFT: cfg_o.phase_shift <= wdata_i;
          REG_OUT_SEL:     cfg_o.out_sel     <= wdata_i[OUT_SEL_BITS-1:0];
          REG_LPF_SHIFT:   cfg_o.lpf_shift   <= wdata_i[LPF_SHIFT_BITS-1:0];
          REG_NA_AVG:      cfg_o.na_avg      <= wdata_i;
          REG_NA_SLEEP:    cfg_o.na_sleep    <= wdata_i;
          default: ;  // sums are read only
        endcase
      end
    end
  end

  // readback, valid with ack
  always_ff @(posedge clk_i) begin
    case (addr_i)
      REG_PHASE_INC:   rdata_o <= cfg_o.phase_inc;
      REG_PHASE_SHIFT: rdata_o <= cfg_o.phase_shift;
      REG_OUT_SEL:     rdata_o <= DATA_BITS'(cfg_o.out_sel);
      REG_LPF_SHIFT:   rdata_o <= DATA_BITS'(cfg_o.lpf_shift);
      REG_NA_AVG:      rdata_o <= cfg_o.na_avg;
      REG_NA_SLEEP:    rdata_o <= cfg_o.na_sleep;
      // sum halves carry busy on top
      REG_SUM_I_LO:    rdata_o <= {busy_i, sums_i.i[DATA_BITS-2:0]};
      REG_SUM_I_HI:    rdata_o <= {busy_i, sums_i.i[SUM_BITS-1:DATA_BITS-1]};
      REG_SUM_Q_LO:    rdata_o <= {busy_i, sums_i.q[DATA_BITS-2:0]};
      REG_SUM_Q_HI:    rdata_o <= {busy_i, sums_i.q[SUM_BITS-1:DATA_BITS-1]};
      default:         rdata_o <= '0;  // unmapped
    endcase
  end

  // no spurious acks
  a_ack_after_access: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    ack_o |-> $past(wen_i || ren_i)
  );

endmodule

//--- logic/iq_top.sv
// --------------------
// iq demodulator top
// nco, demod, low-pass, averager, output
// and the register bank
// --------------------
module iq_top #(
  parameter int SIGNAL_BITS = iq_params_pkg::SIGNAL_BITS,
  parameter int LUT_SZ      = iq_params_pkg::LUT_SZ,
  parameter int PHASE_BITS  = iq_params_pkg::PHASE_BITS
) (
  input  logic                                clk_i,
  input  logic                                rstn_i,
  input  logic                                sync_i,     // holds nco phase at zero
  input  logic signed [SIGNAL_BITS-1:0]       dat_i,
  input  logic [iq_params_pkg::ADDR_BITS-1:0] addr_i,
  input  logic                                wen_i,
  input  logic                                ren_i,
  input  logic [iq_params_pkg::DATA_BITS-1:0] wdata_i,
  output logic                                ack_o,
  output logic [iq_params_pkg::DATA_BITS-1:0] rdata_o,
  output logic signed [SIGNAL_BITS-1:0]       signal_o,
  output logic signed [SIGNAL_BITS-1:0]       signal2_o   // q quadrature
);
  import iq_types_pkg::*;

  iq_cfg_t    cfg;
  logic       start;      // averager kick
  ref_pair_t  ref_pair;
  quad_pair_t quad_raw;   // straight from the multipliers
  quad_pair_t quad_filt;  // after low-pass
  sum_pair_t  sums;
  logic       busy;

  iq_regs u_regs (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .addr_i  (addr_i),
    .wen_i   (wen_i),
    .ren_i   (ren_i),
    .wdata_i (wdata_i),
    .ack_o   (ack_o),
    .rdata_o (rdata_o),
    .cfg_o   (cfg),
    .start_o (start),
    .sums_i  (sums),
    .busy_i  (busy)
  );

  iq_nco #(.LUT_SZ(LUT_SZ), .PHASE_BITS(PHASE_BITS)) u_nco (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .sync_i (sync_i),
    .cfg_i  (cfg),
    .ref_o  (ref_pair)
  );

  iq_demod #(.SIGNAL_BITS(SIGNAL_BITS)) u_demod (
    .clk_i  (clk_i),
    .dat_i  (dat_i),
    .ref_i  (ref_pair),
    .quad_o (quad_raw)
  );

  iq_lowpass u_lowpass (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .cfg_i  (cfg),
    .quad_i (quad_raw),
    .quad_o (quad_filt)
  );

  iq_averager u_averager (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (start),
    .cfg_i   (cfg),
    .quad_i  (quad_filt),
    .sums_o  (sums),
    .busy_o  (busy)
  );

  iq_output_stage #(.SIGNAL_BITS(SIGNAL_BITS)) u_output_stage (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .dat_i     (dat_i),
    .cfg_i     (cfg),
    .quad_i    (quad_filt),
    .signal_o  (signal_o),
    .signal2_o (signal2_o)
  );

endmodule

//--- logic/iq_types_pkg.sv
// --------------------
// iq demodulator types
// config record and the datapath pairs
// --------------------
package iq_types_pkg;

  // register bank contents, all zero after reset
  typedef struct packed {
    logic [iq_params_pkg::PHASE_BITS-1:0]     phase_inc;    // nco step per cycle
    logic [iq_params_pkg::PHASE_BITS-1:0]     phase_shift;  // reference phase offset
    logic [iq_params_pkg::OUT_SEL_BITS-1:0]   out_sel;
    logic [iq_params_pkg::LPF_SHIFT_BITS-1:0] lpf_shift;
    logic [iq_params_pkg::CNT_BITS-1:0]       na_avg;       // cycles to sum
    logic [iq_params_pkg::CNT_BITS-1:0]       na_sleep;     // settling cycles
  } iq_cfg_t;

  // nco reference
  typedef struct packed {
    logic signed [iq_params_pkg::LUT_BITS-1:0] sin;
    logic signed [iq_params_pkg::LUT_BITS-1:0] cos;
  } ref_pair_t;

  // demodulated quadratures
  typedef struct packed {
    logic signed [iq_params_pkg::LPF_BITS-1:0] i;
    logic signed [iq_params_pkg::LPF_BITS-1:0] q;
  } quad_pair_t;

  // averager accumulators
  typedef struct packed {
    logic signed [iq_params_pkg::SUM_BITS-1:0] i;
    logic signed [iq_params_pkg::SUM_BITS-1:0] q;
  } sum_pair_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the iq demodulator testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module iq_tb --Mdir obj_dir -o iq_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/iq_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0
